// File: asa_proc.f
+incdir+hw
hw/asa_pkt_pkg.sv
hw/asa_tbl_pkg.sv
hw/ram_1r1w.sv
hw/ras_decode.sv
hw/asa_process.sv
hw/asa_unit.sv
dv/tb_asa_unit.sv

// File: dv/tb_asa_unit.sv
// testbench for the action-set processing unit
// directed tests against a model of the policy, flow and topic tables
`timescale 1ns/1ps
`default_nettype none
`include "asa_cfg.svh"

module tb_asa_unit;

	localparam int clk_period = 8;
	localparam int n_pkts = 64;
	localparam int cyc_per_pkt = 6;
	localparam int extra_cyc = 300;
	localparam int timeout_ns = (n_pkts * cyc_per_pkt + extra_cyc) * clk_period;

	typedef struct packed {
		logic disc;
		logic [7:0] vec;
		logic [1:0] pri;
		logic mcast;
		asa_pkt_pkg::enq_desc_t desc;
		logic [4:0] tid;
		logic cls_valid;
		logic [5:0] cls_fid;
		logic tset;
		logic [7:0] tset_waddr;
		logic [15:0] tset_wdata;
	} exp_t;

	logic clk;
	logic arst_n;
	logic [31:0] current_time;
	logic [15:0] default_sub_exp_time;
	logic [2:0] supervisor_sci;
	logic [15:0] class2pri;
	logic proc_valid;
	logic proc_type3;
	asa_pkt_pkg::asa_meta_t proc_meta;
	asa_pkt_pkg::ras_t proc_ras;
	logic proc_discard;
	logic fp_wr;
	logic [5:0] fp_waddr;
	asa_tbl_pkg::flow_policy_t fp_wdata;
	logic classifier_valid;
	logic [5:0] classifier_fid;
	logic tset_wr;
	logic [7:0] tset_waddr;
	logic [15:0] tset_wdata;
	logic enq_req;
	logic enq_discard;
	logic enq_mcast;
	logic [7:0] enq_vec;
	logic [1:0] enq_pri;
	asa_pkt_pkg::enq_desc_t enq_desc;
	logic [4:0] enq_tid;

	asa_tbl_pkg::flow_policy_t pol_m [64];
	asa_tbl_pkg::flow_action_t fa_m [64];
	logic [7:0] ta_m [32];
	exp_t exp_q [$];
	int due_q [$];
	int cyc;
	logic checking;
	string cur_test;

	asa_unit u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	initial begin
		#(timeout_ns);
		$display("watchdog: run did not finish within %0d ns", timeout_ns);
		$display("sim failed");
		$fatal(1);
	end

	// --------------------------------------------------
	// checking helpers
	// --------------------------------------------------
	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
		assert (exp === act) else
			fail_stop($sformatf("Fail %s %s: expected %0h actual %0h", cur_test, what, exp, act));
	endtask

	function automatic logic [7:0] onehot(input logic [2:0] sci);
		return 8'b1 << sci;
	endfunction

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		exp_t e;
		if (checking) begin
			if (enq_req) begin
				assert (due_q.size() != 0 && due_q[0] == cyc) else
					fail_stop($sformatf("%s: enq_req pulsed with no packet due", cur_test));
				e = exp_q.pop_front();
				void'(due_q.pop_front());
				check_val("enq_discard", 64'(e.disc), 64'(enq_discard));
				check_val("enq_vec", 64'(e.vec), 64'(enq_vec));
				check_val("enq_pri", 64'(e.pri), 64'(enq_pri));
				check_val("enq_mcast", 64'(e.mcast), 64'(enq_mcast));
				check_val("enq_desc", 64'(e.desc), 64'(enq_desc));
				check_val("enq_tid", 64'(e.tid), 64'(enq_tid));
				check_val("classifier_valid", 64'(e.cls_valid), 64'(classifier_valid));
				if (e.cls_valid)
					check_val("classifier_fid", 64'(e.cls_fid), 64'(classifier_fid));
				check_val("tset_wr", 64'(e.tset), 64'(tset_wr));
				if (e.tset) begin
					check_val("tset_waddr", 64'(e.tset_waddr), 64'(tset_waddr));
					check_val("tset_wdata", 64'(e.tset_wdata), 64'(tset_wdata));
				end
			end else begin
				assert (!classifier_valid && !tset_wr) else
					fail_stop($sformatf("%s: strobe without enq_req", cur_test));
				assert (due_q.size() == 0 || due_q[0] != cyc) else
					fail_stop($sformatf("%s: enq_req missing for a packet", cur_test));
			end
		end
	end

	// --------------------------------------------------
	// reference model of the d2 rules
	// --------------------------------------------------
	task automatic predict(input logic t3, input asa_pkt_pkg::asa_meta_t m,
		input asa_pkt_pkg::ras_t r, input logic pd, output exp_t e);
		asa_tbl_pkg::flow_policy_t p;
		asa_tbl_pkg::flow_action_t f;
		logic [7:0] tv, fvec, tvec, v;
		logic fany, dd, ok, ue, dsc;
		logic [2:0] ea;
		logic [1:0] dt;
		logic [31:0] et;
		p = pol_m[m.fid];
		f = fa_m[m.fid];
		tv = ta_m[m.tid];
		ea = r.flag.east;
		dt = f.default_type;
		fvec = '0;
		fany = 1'b0;
		for (int i = 0; i < 8; i++) begin
			if (r.slot[i].used) begin
				fvec = fvec | onehot(r.slot[i].sci);
				fany = 1'b1;
			end
		end
		tvec = r.slot[8].used ? onehot(r.slot[8].sci) : 8'h00;
		dd = m.type1 && (m.domain_id != p.domain_id);
		ok = !t3 && !dd && !m.discard && ea[2];
		ue = r.flag.nfascf[1] && ea[1] && p.maskon.exec_fwd;
		if (t3) begin
			v = ((dt[0] && p.maskon.tsas_fwd) ? tv : 8'h00)
				| ((dt[1] && p.maskon.fsas_fwd) ? f.vec : 8'h00);
			dsc = (dt == 2'b00);
		end else begin
			v = ((ea[0] && p.maskon.tsas_fwd) ? tv : 8'h00)
				| (ue ? fvec : 8'h00)
				| ((ea[0] && p.maskon.exec_fwd) ? tvec : 8'h00)
				| ((!ue && p.maskon.fsas_fwd) ? f.vec : 8'h00);
			dsc = (ea[1:0] == 2'b00);
		end
		v = v & ~onehot(m.rci);
		if (!p.maskon.fwd_supervisor)
			v = v & ~onehot(supervisor_sci);
		et = current_time + {default_sub_exp_time, 16'h0000};
		e.disc = dsc || m.discard || dd || pd;
		e.vec = v;
		e.pri = class2pri[2 * p.tclass +: 2];
		e.mcast = p.maskon.mcast;
		e.desc = '{m.src_port, m.dst_port, m.buf_ptr, r.flag.uppp, r.flag.uppd && p.maskon.upd_ppd};
		e.tid = m.tid;
		e.cls_valid = !ea[2];
		e.cls_fid = m.fid;
		e.tset = ok && ea[0] && r.slot[8].used && p.maskon.upd_tas;
		e.tset_waddr = {m.tid, r.slot[8].sci};
		e.tset_wdata = et[31:16];
		// table learning
		if (ok && ea[1] && r.flag.nfascf == 2'b11 && fany && p.maskon.upd_fas)
			fa_m[m.fid].vec = fvec;
		if (ok && r.flag.ufdast[2] && p.maskon.upd_fas)
			fa_m[m.fid].default_type = asa_tbl_pkg::action_set_type_e'(r.flag.ufdast[1:0]);
		if (e.tset)
			ta_m[m.tid] = tv | tvec;
	endtask

	// --------------------------------------------------
	// stimulus helpers, called right after a falling edge
	// --------------------------------------------------
	function automatic asa_pkt_pkg::asa_meta_t mk_meta(input logic [5:0] fid,
		input logic [4:0] tid, input logic [2:0] rci, input logic [3:0] dom,
		input logic type1, input logic disc);
		asa_pkt_pkg::asa_meta_t m;
		m.fid = fid;
		m.tid = tid;
		m.rci = rci;
		m.domain_id = dom;
		m.type1 = type1;
		m.discard = disc;
		m.src_port = 4'($urandom);
		m.dst_port = 4'($urandom);
		m.buf_ptr = 12'($urandom);
		return m;
	endfunction

	function automatic asa_pkt_pkg::ras_t mk_ras(input asa_pkt_pkg::east_e ea,
		input logic [2:0] uf, input logic [1:0] nf, input int nflow,
		input logic tused, input logic [2:0] tsci);
		asa_pkt_pkg::ras_t r;
		for (int i = 0; i < 8; i++) begin
			r.slot[i].used = (i < nflow);
			r.slot[i].sci = 3'($urandom);
		end
		r.slot[8].used = tused;
		r.slot[8].sci = tsci;
		r.flag.east = ea;
		r.flag.ufdast = uf;
		r.flag.nfascf = nf;
		r.flag.uppp = 1'($urandom);
		r.flag.uppd = 1'($urandom);
		return r;
	endfunction

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic write_policy(input logic [5:0] fid, input logic [3:0] dom,
		input logic [2:0] tclass, input logic [7:0] maskon);
		fp_wr = 1'b1;
		fp_waddr = fid;
		fp_wdata = '{dom, tclass, asa_tbl_pkg::flow_maskon_t'(maskon)};
		pol_m[fid] = fp_wdata;
		@(negedge clk);
		fp_wr = 1'b0;
		idle(1);  // config register stage
	endtask

	task automatic send_pkt(input logic t3, input asa_pkt_pkg::asa_meta_t m,
		input asa_pkt_pkg::ras_t r, input logic pd);
		exp_t e;
		predict(t3, m, r, pd, e);
		exp_q.push_back(e);
		due_q.push_back(cyc + 3);
		proc_valid = 1'b1;
		proc_type3 = t3;
		proc_meta = m;
		proc_ras = r;
		proc_discard = pd;
		@(negedge clk);
		proc_valid = 1'b0;
		proc_discard = 1'b0;
	endtask

	task automatic drain();
		while (due_q.size() != 0)
			@(negedge clk);
		idle(1);
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic test_reset_config();
		cur_test = "reset_config";
		check_val("enq_req", 64'd0, 64'(enq_req));
		check_val("classifier_valid", 64'd0, 64'(classifier_valid));
		check_val("tset_wr", 64'd0, 64'(tset_wr));
		class2pri = 16'($urandom);
		for (int i = 1; i <= 4; i++)
			write_policy(6'(i), 4'd3, 3'(2 * i - 1), (i % 2 == 0) ? 8'h48 : 8'h08);
		for (int i = 1; i <= 4; i++)
			send_pkt(1'b0, mk_meta(6'(i), 5'(i), 3'($urandom), 4'd3, 1'b1, 1'b0),
				mk_ras(asa_pkt_pkg::east_cont_flow, 3'b000, 2'b10, 3, 1'b0, 3'd0), 1'b0);
		drain();
	endtask

	task automatic test_discards();
		cur_test = "discards";
		write_policy(6'd6, 4'd2, 3'd2, 8'h08);
		send_pkt(1'b0, mk_meta(6'd6, 5'd6, 3'd1, 4'd5, 1'b1, 1'b0),
			mk_ras(asa_pkt_pkg::east_cont_flow, 3'b000, 2'b10, 2, 1'b0, 3'd0), 1'b0);
		idle(2);
		send_pkt(1'b0, mk_meta(6'd6, 5'd6, 3'd1, 4'd2, 1'b1, 1'b0),
			mk_ras(asa_pkt_pkg::east_cont_drop, 3'b000, 2'b10, 2, 1'b0, 3'd0), 1'b0);
		idle(2);
		send_pkt(1'b0, mk_meta(6'd6, 5'd6, 3'd1, 4'd2, 1'b1, 1'b1),
			mk_ras(asa_pkt_pkg::east_cont_flow, 3'b000, 2'b10, 2, 1'b0, 3'd0), 1'b0);
		idle(2);
		send_pkt(1'b0, mk_meta(6'd6, 5'd6, 3'd1, 4'd2, 1'b1, 1'b0),
			mk_ras(asa_pkt_pkg::east_cont_flow, 3'b000, 2'b10, 2, 1'b0, 3'd0), 1'b1);
		drain();
	endtask

	task automatic test_learning();
		cur_test = "learning";
		write_policy(6'd8, 4'd1, 3'd4, 8'h36);  // learn and forward stored sets
		write_policy(6'd9, 4'd1, 3'd6, 8'h36);
		send_pkt(1'b0, mk_meta(6'd8, 5'd8, 3'd0, 4'd1, 1'b0, 1'b0),
			mk_ras(asa_pkt_pkg::east_cont_both, 3'b111, 2'b11, 4, 1'b1, 3'd2), 1'b0);
		send_pkt(1'b0, mk_meta(6'd9, 5'd9, 3'd0, 4'd1, 1'b0, 1'b0),
			mk_ras(asa_pkt_pkg::east_cont_both, 3'b101, 2'b11, 5, 1'b1, 3'd6), 1'b0);
		idle(2);
		send_pkt(1'b1, mk_meta(6'd8, 5'd8, 3'd7, 4'd1, 1'b0, 1'b0),
			mk_ras(asa_pkt_pkg::east_cont_drop, 3'b000, 2'b00, 0, 1'b0, 3'd0), 1'b0);
		send_pkt(1'b1, mk_meta(6'd9, 5'd9, 3'd7, 4'd1, 1'b0, 1'b0),
			mk_ras(asa_pkt_pkg::east_cont_drop, 3'b000, 2'b00, 0, 1'b0, 3'd0), 1'b0);
		drain();
	endtask

	task automatic test_masks();
		cur_test = "masks";
		supervisor_sci = 3'($urandom);
		for (int i = 0; i < 24; i++)
			write_policy(6'(16 + i), 4'd7, 3'(i), (i % 2 == 1) ? 8'h88 : 8'h08);
		for (int i = 0; i < 24; i++) begin
			send_pkt(1'b0, mk_meta(6'(16 + i), 5'(i), 3'($urandom), 4'd7, 1'b1, 1'b0),
				mk_ras(asa_pkt_pkg::east_cont_both, 3'b000, 2'b10, 1 + ($urandom % 8),
				1'($urandom), 3'($urandom)), 1'b0);
			idle(1);
		end
		drain();
	endtask

	task automatic test_term_expiry();
		cur_test = "term_expiry";
		current_time = $urandom;
		default_sub_exp_time = 16'($urandom);
		write_policy(6'd50, 4'd0, 3'd1, 8'h0c);
		write_policy(6'd51, 4'd0, 3'd3, 8'h0c);
		write_policy(6'd52, 4'd0, 3'd5, 8'h0c);
		send_pkt(1'b0, mk_meta(6'd50, 5'd20, 3'd1, 4'd0, 1'b0, 1'b0),
			mk_ras(asa_pkt_pkg::east_term_both, 3'b000, 2'b10, 2, 1'b1, 3'd5), 1'b0);
		send_pkt(1'b0, mk_meta(6'd51, 5'd21, 3'd1, 4'd0, 1'b0, 1'b0),
			mk_ras(asa_pkt_pkg::east_term_flow, 3'b000, 2'b10, 3, 1'b0, 3'd0), 1'b0);
		// continuing topic update writes the expiry table
		send_pkt(1'b0, mk_meta(6'd52, 5'd22, 3'd1, 4'd0, 1'b0, 1'b0),
			mk_ras(asa_pkt_pkg::east_cont_topic, 3'b000, 2'b10, 1, 1'b1, 3'd4), 1'b0);
		drain();
	endtask

	task automatic test_back_to_back();
		asa_pkt_pkg::east_e ea;
		cur_test = "back_to_back";
		for (int i = 0; i < 6; i++)
			write_policy(6'(56 + i), 4'd9, 3'(i), 8'h49);
		for (int i = 0; i < 6; i++) begin
			ea = (i % 3 == 0) ? asa_pkt_pkg::east_cont_flow :
				(i % 3 == 1) ? asa_pkt_pkg::east_cont_both : asa_pkt_pkg::east_term_topic;
			send_pkt(1'b0, mk_meta(6'(56 + i), 5'(24 + i), 3'($urandom), 4'd9, 1'b1, 1'b0),
				mk_ras(ea, 3'b000, 2'b10, 1 + i, 1'b1, 3'($urandom)), 1'b0);
		end
		drain();
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		void'($urandom(32'hf3e7));
		cyc = 0;
		checking = 1'b0;
		cur_test = "init";
		arst_n = 1'b0;
		current_time = 32'h0001_0000;
		default_sub_exp_time = 16'h0010;
		supervisor_sci = 3'd7;
		class2pri = 16'h0000;
		proc_valid = 1'b0;
		proc_type3 = 1'b0;
		proc_meta = '0;
		proc_ras = '0;
		proc_discard = 1'b0;
		fp_wr = 1'b0;
		fp_waddr = '0;
		fp_wdata = '0;
		for (int i = 0; i < 64; i++) begin
			pol_m[i] = '0;
			fa_m[i] = '0;
		end
		for (int i = 0; i < 32; i++)
			ta_m[i] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		checking = 1'b1;
		test_reset_config();
		test_discards();
		test_learning();
		test_masks();
		test_term_expiry();
		test_back_to_back();
		assert (due_q.size() == 0) else
			fail_stop("packets still outstanding at the end of the run");
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/asa_cfg.svh
// action-set stage configuration
// widths of channels, table indices, time fields and the packet descriptor
`ifndef ASA_CFG_SVH
`define ASA_CFG_SVH

// subscriber channels
`define ASA_SCI_NBITS 3
`define ASA_SCI_VEC_NBITS 8

// table indices
`define ASA_FID_NBITS 6
`define ASA_TID_NBITS 5

// eight flow slots then one topic slot
`define ASA_RAS_SLOTS 9

// expiry arithmetic
`define ASA_TIME_NBITS 32
`define ASA_SUB_EXP_NBITS 16

// packet descriptor fields
`define ASA_PRI_NBITS 2
`define ASA_DOMAIN_NBITS 4
`define ASA_BUF_NBITS 12
`define ASA_PORT_NBITS 4

`endif

// File: hw/asa_pkt_pkg.sv
// packet side types of the action-set stage
// metadata, rule action set, decoded action set and enqueue descriptor
`default_nettype none
`include "asa_cfg.svh"

package asa_pkt_pkg;

	// bit2 continue, bit1 flow part, bit0 topic part
	typedef enum logic [2:0] {
		east_term_drop  = 3'b000,
		east_term_topic = 3'b001,
		east_term_flow  = 3'b010,
		east_term_both  = 3'b011,
		east_cont_drop  = 3'b100,
		east_cont_topic = 3'b101,
		east_cont_flow  = 3'b110,
		east_cont_both  = 3'b111
	} east_e;

	typedef struct packed {
		east_e east;
		logic [2:0] ufdast;  // bit2 update default, 1:0 new type
		logic [1:0] nfascf;
		logic uppp;
		logic uppd;
	} ras_flag_t;

	typedef struct packed {
		logic used;
		logic [`ASA_SCI_NBITS-1:0] sci;
	} ras_slot_t;

	typedef struct packed {
		ras_slot_t [`ASA_RAS_SLOTS-1:0] slot;  // slot 8 is the topic slot
		ras_flag_t flag;
	} ras_t;

	typedef struct packed {
		logic [`ASA_SCI_VEC_NBITS-1:0] flow_vec;
		logic flow_any;
		logic [`ASA_SCI_VEC_NBITS-1:0] topic_vec;
		logic topic_valid;
		logic [`ASA_SCI_NBITS-1:0] topic_sci;
		ras_flag_t flag;
	} ras_dec_t;

	typedef struct packed {
		logic [`ASA_FID_NBITS-1:0] fid;
		logic [`ASA_TID_NBITS-1:0] tid;
		logic [`ASA_SCI_NBITS-1:0] rci;  // receive channel
		logic [`ASA_DOMAIN_NBITS-1:0] domain_id;
		logic type1;
		logic discard;
		logic [`ASA_PORT_NBITS-1:0] src_port;
		logic [`ASA_PORT_NBITS-1:0] dst_port;
		logic [`ASA_BUF_NBITS-1:0] buf_ptr;
	} asa_meta_t;

	typedef struct packed {
		logic [`ASA_PORT_NBITS-1:0] src_port;
		logic [`ASA_PORT_NBITS-1:0] dst_port;
		logic [`ASA_BUF_NBITS-1:0] buf_ptr;
		logic ptr_update;
		logic pd_update;
	} enq_desc_t;

	// channel index to one-hot channel bit
	function automatic logic [`ASA_SCI_VEC_NBITS-1:0] sci2vec(
		input logic [`ASA_SCI_NBITS-1:0] sci
	);
		sci2vec = '0;
		sci2vec[sci] = 1'b1;
	endfunction

endpackage

`default_nettype wire

// File: hw/asa_process.sv
// action-set processing pipeline
// reads policy, flow and topic action tables, learns new action sets and
// decides drop, channel vector and priority; outputs three cycles after input
`timescale 1ns/1ps
`default_nettype none
`include "asa_cfg.svh"

module asa_process (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic [`ASA_TIME_NBITS-1:0] current_time,
	input  wire logic [`ASA_SUB_EXP_NBITS-1:0] default_sub_exp_time,
	input  wire logic [`ASA_SCI_NBITS-1:0] supervisor_sci,
	input  wire logic [8*`ASA_PRI_NBITS-1:0] class2pri,
	input  wire logic proc_valid,
	input  wire logic proc_type3,
	input  wire asa_pkt_pkg::asa_meta_t proc_meta,
	input  wire asa_pkt_pkg::ras_t proc_ras,
	input  wire logic proc_discard,
	input  wire logic fp_wr,
	input  wire logic [`ASA_FID_NBITS-1:0] fp_waddr,
	input  wire asa_tbl_pkg::flow_policy_t fp_wdata,
	output logic classifier_valid,
	output logic [`ASA_FID_NBITS-1:0] classifier_fid,
	output logic tset_wr,
	output logic [`ASA_TID_NBITS+`ASA_SCI_NBITS-1:0] tset_waddr,
	output logic [`ASA_SUB_EXP_NBITS-1:0] tset_wdata,
	output logic enq_req,
	output logic enq_discard,
	output logic enq_mcast,
	output logic [`ASA_SCI_VEC_NBITS-1:0] enq_vec,
	output logic [`ASA_PRI_NBITS-1:0] enq_pri,
	output asa_pkt_pkg::enq_desc_t enq_desc,
	output logic [`ASA_TID_NBITS-1:0] enq_tid
);

	localparam int vec_nbits = `ASA_SCI_VEC_NBITS;

	logic valid_d1, valid_d2;
	logic type3_d1, type3_d2;
	logic discard_d1, discard_d2;
	asa_pkt_pkg::asa_meta_t meta_d1, meta_d2;
	logic [`ASA_TIME_NBITS-1:0] time_q;

	asa_pkt_pkg::ras_dec_t dec, dec_q;
	asa_tbl_pkg::flow_policy_t fp_rdata, fp_q;
	asa_tbl_pkg::flow_action_t fa_rdata, fa_q, fa_wdata;
	logic [vec_nbits-1:0] ta_rdata, ta_q, ta_wdata;

	asa_pkt_pkg::east_e east;
	asa_tbl_pkg::flow_maskon_t mo;
	asa_tbl_pkg::action_set_type_e dt;
	logic dom_drop, ok;
	logic fa_vec_wr, fa_type_wr, fa_wr, ta_wr;
	logic use_eflow;
	logic [vec_nbits-1:0] fwd_vec, sup_mask, vec_nxt;
	logic discard_nxt;
	logic [`ASA_TIME_NBITS-1:0] exp_time;

	// --------------------------------------------------
	// tables and decode, read with proc_valid
	// --------------------------------------------------
	ram_1r1w #(.width($bits(asa_tbl_pkg::flow_policy_t)), .addr_nbits(`ASA_FID_NBITS)) u_fp_ram (
		.clk(clk), .wr(fp_wr), .waddr(fp_waddr), .din(fp_wdata),
		.raddr(proc_meta.fid), .dout(fp_rdata)
	);

	ram_1r1w #(.width($bits(asa_tbl_pkg::flow_action_t)), .addr_nbits(`ASA_FID_NBITS)) u_fa_ram (
		.clk(clk), .wr(fa_wr), .waddr(meta_d2.fid), .din(fa_wdata),
		.raddr(proc_meta.fid), .dout(fa_rdata)
	);

	ram_1r1w #(.width(vec_nbits), .addr_nbits(`ASA_TID_NBITS)) u_ta_ram (
		.clk(clk), .wr(ta_wr), .waddr(meta_d2.tid), .din(ta_wdata),
		.raddr(proc_meta.tid), .dout(ta_rdata)
	);

	ras_decode u_ras_decode (.clk(clk), .arst_n(arst_n), .ras(proc_ras), .dec(dec));

	// --------------------------------------------------
	// pipeline registers
	// --------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_d1 <= 1'b0;
			valid_d2 <= 1'b0;
		end else begin
			valid_d1 <= proc_valid;
			valid_d2 <= valid_d1;
		end
	end

	always_ff @(posedge clk) begin
		type3_d1 <= proc_type3;
		type3_d2 <= type3_d1;
		discard_d1 <= proc_discard;
		discard_d2 <= discard_d1;
		meta_d1 <= proc_meta;
		meta_d2 <= meta_d1;
		time_q <= current_time;  // time seen during d1
		dec_q <= dec;
		fp_q <= fp_rdata;
		fa_q <= fa_rdata;
		ta_q <= ta_rdata;
	end

	// --------------------------------------------------
	// d2 decision and table write-back
	// --------------------------------------------------
	assign east = dec_q.flag.east;
	assign mo = fp_q.maskon;
	assign dt = fa_q.default_type;

	assign dom_drop = meta_d2.type1 && (meta_d2.domain_id != fp_q.domain_id);
	assign ok = valid_d2 && !type3_d2 && !dom_drop && !meta_d2.discard && east[2];

	assign fa_vec_wr = ok && east[1] && (dec_q.flag.nfascf == 2'b11) && dec_q.flow_any && mo.upd_fas;
	assign fa_type_wr = ok && dec_q.flag.ufdast[2] && mo.upd_fas;
	assign fa_wr = fa_vec_wr || fa_type_wr;
	assign fa_wdata.vec = fa_vec_wr ? dec_q.flow_vec : fa_q.vec;
	assign fa_wdata.default_type = fa_type_wr ?
		asa_tbl_pkg::action_set_type_e'(dec_q.flag.ufdast[1:0]) : dt;

	assign ta_wr = ok && east[0] && dec_q.topic_valid && mo.upd_tas;
	assign ta_wdata = ta_q | dec_q.topic_vec;

	assign use_eflow = dec_q.flag.nfascf[1] && east[1] && mo.exec_fwd;

	always_comb begin
		if (type3_d2) begin
			// stored default type stands in for east
			fwd_vec = ((dt[0] && mo.tsas_fwd) ? ta_q : '0)
				| ((dt[1] && mo.fsas_fwd) ? fa_q.vec : '0);
			discard_nxt = (dt == asa_tbl_pkg::as_none);
		end else begin
			fwd_vec = ((east[0] && mo.tsas_fwd) ? ta_q : '0)
				| (use_eflow ? dec_q.flow_vec : '0)
				| ((east[0] && mo.exec_fwd) ? dec_q.topic_vec : '0)
				| ((!use_eflow && mo.fsas_fwd) ? fa_q.vec : '0);
			discard_nxt = (east[1:0] == 2'b00);
		end
	end

	assign sup_mask = mo.fwd_supervisor ? '1 : ~asa_pkt_pkg::sci2vec(supervisor_sci);
	assign vec_nxt = fwd_vec & ~asa_pkt_pkg::sci2vec(meta_d2.rci) & sup_mask;

	assign exp_time = time_q + {default_sub_exp_time, {(`ASA_TIME_NBITS-`ASA_SUB_EXP_NBITS){1'b0}}};

	// --------------------------------------------------
	// output registers
	// --------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			enq_req <= 1'b0;
			classifier_valid <= 1'b0;
			tset_wr <= 1'b0;
		end else begin
			enq_req <= valid_d2;
			classifier_valid <= valid_d2 && !east[2];  // flow terminates
			tset_wr <= ta_wr;
		end
	end

	always_ff @(posedge clk) begin
		enq_discard <= discard_nxt || meta_d2.discard || dom_drop || discard_d2;
		enq_vec <= vec_nxt;
		enq_mcast <= mo.mcast;
		enq_pri <= class2pri[fp_q.tclass*`ASA_PRI_NBITS +: `ASA_PRI_NBITS];
		enq_tid <= meta_d2.tid;
		enq_desc.src_port <= meta_d2.src_port;
		enq_desc.dst_port <= meta_d2.dst_port;
		enq_desc.buf_ptr <= meta_d2.buf_ptr;
		enq_desc.ptr_update <= dec_q.flag.uppp;
		enq_desc.pd_update <= dec_q.flag.uppd && mo.upd_ppd;
		classifier_fid <= meta_d2.fid;
		tset_waddr <= {meta_d2.tid, dec_q.topic_sci};
		tset_wdata <= exp_time[`ASA_TIME_NBITS-1 -: `ASA_SUB_EXP_NBITS];
	end

	// every accepted packet reaches the replication queue three cycles later
	ast_enq_latency: assert property (@(posedge clk) disable iff (!arst_n)
		proc_valid |-> ##3 enq_req);

endmodule

`default_nettype wire

// File: hw/asa_tbl_pkg.sv
// table entry types of the action-set stage
// flow policy, flow action set and the action-set type
`default_nettype none
`include "asa_cfg.svh"

package asa_tbl_pkg;

	typedef enum logic [1:0] {
		as_none  = 2'b00,
		as_topic = 2'b01,
		as_flow  = 2'b10,
		as_both  = 2'b11
	} action_set_type_e;

	// --------------------------------------------------
	// flow policy, written from the config port only
	// --------------------------------------------------
	typedef struct packed {
		logic fwd_supervisor;
		logic mcast;
		logic tsas_fwd;  // forward on stored topic set
		logic fsas_fwd;  // forward on stored flow set
		logic exec_fwd;
		logic upd_tas;
		logic upd_fas;
		logic upd_ppd;
	} flow_maskon_t;

	typedef struct packed {
		logic [`ASA_DOMAIN_NBITS-1:0] domain_id;
		logic [2:0] tclass;
		flow_maskon_t maskon;
	} flow_policy_t;

	typedef struct packed {
		action_set_type_e default_type;
		logic [`ASA_SCI_VEC_NBITS-1:0] vec;
	} flow_action_t;

endpackage

`default_nettype wire

// File: hw/asa_unit.sv
// action-set processing unit
// registers flow policy configuration writes and feeds the processing pipeline
`timescale 1ns/1ps
`default_nettype none
`include "asa_cfg.svh"

module asa_unit (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic [`ASA_TIME_NBITS-1:0] current_time,
	input  wire logic [`ASA_SUB_EXP_NBITS-1:0] default_sub_exp_time,
	input  wire logic [`ASA_SCI_NBITS-1:0] supervisor_sci,
	input  wire logic [8*`ASA_PRI_NBITS-1:0] class2pri,
	input  wire logic proc_valid,
	input  wire logic proc_type3,
	input  wire asa_pkt_pkg::asa_meta_t proc_meta,
	input  wire asa_pkt_pkg::ras_t proc_ras,
	input  wire logic proc_discard,
	input  wire logic fp_wr,
	input  wire logic [`ASA_FID_NBITS-1:0] fp_waddr,
	input  wire asa_tbl_pkg::flow_policy_t fp_wdata,
	output logic classifier_valid,
	output logic [`ASA_FID_NBITS-1:0] classifier_fid,
	output logic tset_wr,
	output logic [`ASA_TID_NBITS+`ASA_SCI_NBITS-1:0] tset_waddr,
	output logic [`ASA_SUB_EXP_NBITS-1:0] tset_wdata,
	output logic enq_req,
	output logic enq_discard,
	output logic enq_mcast,
	output logic [`ASA_SCI_VEC_NBITS-1:0] enq_vec,
	output logic [`ASA_PRI_NBITS-1:0] enq_pri,
	output asa_pkt_pkg::enq_desc_t enq_desc,
	output logic [`ASA_TID_NBITS-1:0] enq_tid
);

	logic fp_wr_q;
	logic [`ASA_FID_NBITS-1:0] fp_waddr_q;
	asa_tbl_pkg::flow_policy_t fp_wdata_q;

	// config write stage
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fp_wr_q <= 1'b0;
		end else begin
			fp_wr_q <= fp_wr;
		end
	end

	always_ff @(posedge clk) begin
		fp_waddr_q <= fp_waddr;
		fp_wdata_q <= fp_wdata;
	end

	asa_process u_process (
		.clk(clk),
		.arst_n(arst_n),
		.current_time(current_time),
		.default_sub_exp_time(default_sub_exp_time),
		.supervisor_sci(supervisor_sci),
		.class2pri(class2pri),
		.proc_valid(proc_valid),
		.proc_type3(proc_type3),
		.proc_meta(proc_meta),
		.proc_ras(proc_ras),
		.proc_discard(proc_discard),
		.fp_wr(fp_wr_q),
		.fp_waddr(fp_waddr_q),
		.fp_wdata(fp_wdata_q),
		.classifier_valid(classifier_valid),
		.classifier_fid(classifier_fid),
		.tset_wr(tset_wr),
		.tset_waddr(tset_waddr),
		.tset_wdata(tset_wdata),
		.enq_req(enq_req),
		.enq_discard(enq_discard),
		.enq_mcast(enq_mcast),
		.enq_vec(enq_vec),
		.enq_pri(enq_pri),
		.enq_desc(enq_desc),
		.enq_tid(enq_tid)
	);

endmodule

`default_nettype wire

// File: hw/ram_1r1w.sv
// simple dual-port table
// one registered read port, one write port, read returns old data on collision
`timescale 1ns/1ps
`default_nettype none

module ram_1r1w #(
	parameter int width = 8,
	parameter int addr_nbits = 4
) (
	input  wire logic clk,
	input  wire logic wr,
	input  wire logic [addr_nbits-1:0] waddr,
	input  wire logic [width-1:0] din,
	input  wire logic [addr_nbits-1:0] raddr,
	output logic [width-1:0] dout
);

	logic [width-1:0] mem [2**addr_nbits];

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
		dout <= mem[raddr];
	end

	ast_wr_known: assert property (@(posedge clk)
		!$isunknown(wr) && (!wr || !$isunknown(waddr)));

endmodule

`default_nettype wire

// File: hw/ras_decode.sv
// rule action set decoder
// unpacks the flow and topic slots into channel vectors, one cycle latency
`timescale 1ns/1ps
`default_nettype none
`include "asa_cfg.svh"

module ras_decode (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire asa_pkt_pkg::ras_t ras,
	output asa_pkt_pkg::ras_dec_t dec
);

	localparam int flow_slots = `ASA_RAS_SLOTS - 1;

	logic [`ASA_SCI_VEC_NBITS-1:0] flow_vec;
	logic flow_any;
	logic [`ASA_SCI_VEC_NBITS-1:0] topic_vec;
	asa_pkt_pkg::ras_slot_t topic_slot;

	logic flow_any_q;
	logic topic_valid_q;
	logic [`ASA_SCI_VEC_NBITS-1:0] flow_vec_q;
	logic [`ASA_SCI_VEC_NBITS-1:0] topic_vec_q;
	logic [`ASA_SCI_NBITS-1:0] topic_sci_q;
	asa_pkt_pkg::ras_flag_t flag_q;

	// --------------------------------------------------
	// slot unpack
	// --------------------------------------------------
	always_comb begin
		flow_vec = '0;
		flow_any = 1'b0;
		for (int i = 0; i < flow_slots; i++) begin
			if (ras.slot[i].used) begin
				flow_vec = flow_vec | asa_pkt_pkg::sci2vec(ras.slot[i].sci);
				flow_any = 1'b1;
			end
		end
	end

	assign topic_slot = ras.slot[flow_slots];
	assign topic_vec = topic_slot.used ? asa_pkt_pkg::sci2vec(topic_slot.sci) : '0;

	// --------------------------------------------------
	// output register
	// --------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flow_any_q <= 1'b0;
			topic_valid_q <= 1'b0;
		end else begin
			flow_any_q <= flow_any;
			topic_valid_q <= topic_slot.used;
		end
	end

	always_ff @(posedge clk) begin
		flow_vec_q <= flow_vec;
		topic_vec_q <= topic_vec;
		topic_sci_q <= topic_slot.sci;
		flag_q <= ras.flag;
	end

	assign dec = '{
		flow_vec: flow_vec_q,
		flow_any: flow_any_q,
		topic_vec: topic_vec_q,
		topic_valid: topic_valid_q,
		topic_sci: topic_sci_q,
		flag: flag_q
	};

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the action-set stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Ihw -f asa_proc.f \
	--top-module tb_asa_unit -o sim_asa > build.log 2>&1 \
	&& ./obj_dir/sim_asa > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
